//--- axis_skid_buffer.sv
// output and temp register pair giving a registered upstream ready
`timescale 1ns/1ps
`default_nettype none

module axis_skid_buffer
    import eth_fcs_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    input  wire axis_beat_t int_beat,
    input  wire logic       int_valid,
    output logic            ready_early,

    output axis_beat_t      out_beat,
    output logic            out_valid,
    input  wire logic       out_ready
);

    axis_beat_t out_beat_q;
    axis_beat_t temp_beat_q;
    logic       out_valid_q;
    logic       temp_valid_q;
    logic       ready_q;

    logic       out_valid_next;
    logic       temp_valid_next;
    logic       store_int_to_out;
    logic       store_int_to_temp;
    logic       store_temp_to_out;

    assign out_beat  = out_beat_q;
    assign out_valid = out_valid_q;

    // ready next cycle unless the temp slot could fill up
    assign ready_early = out_ready | (~temp_valid_q & (~out_valid_q | ~int_valid));

    always_comb begin
        out_valid_next    = out_valid_q;
        temp_valid_next   = temp_valid_q;
        store_int_to_out  = 1'b0;
        store_int_to_temp = 1'b0;
        store_temp_to_out = 1'b0;

        if (ready_q) begin
            if (out_ready | ~out_valid_q) begin
                out_valid_next   = int_valid;
                store_int_to_out = 1'b1;
            end else begin
                // park the beat while the output is stalled
                temp_valid_next   = int_valid;
                store_int_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // drain temp into output
            out_valid_next    = temp_valid_q;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid_q  <= 1'b0;
            temp_valid_q <= 1'b0;
            ready_q      <= 1'b0;
        end else begin
            out_valid_q  <= out_valid_next;
            temp_valid_q <= temp_valid_next;
            ready_q      <= ready_early;
        end
    end

    always_ff @(posedge clk) begin
        if (store_int_to_out) begin
            out_beat_q <= int_beat;
        end else if (store_temp_to_out) begin
            out_beat_q <= temp_beat_q;
        end
        if (store_int_to_temp) begin
            temp_beat_q <= int_beat;
        end
    end

endmodule

`default_nettype wire

//--- eth_crc32_step.sv
// combinational reflected CRC-32 update over a parameterized number of bytes
`timescale 1ns/1ps
`default_nettype none

`include "eth_fcs_macros.svh"

module eth_crc32_step
    import eth_fcs_pkg::*;
#(
    parameter int BYTES = 1
) (
    input  wire logic [BYTES*8-1:0] data_in,
    input  wire crc_t               state_in,
    output crc_t                    state_out
);

    // working copy of the register while bits are shifted in
    crc_t crc;

    // bit-serial Galois LFSR unrolled over the whole input
    // byte 0 goes first and each byte lsb first as on the wire
    always_comb begin
        crc = state_in;
        for (int i = 0; i < BYTES * 8; i++) begin
            if (crc[0] ^ data_in[i]) begin
                crc = (crc >> 1) ^ `ETH_CRC_POLY;
            end else begin
                crc = crc >> 1;
            end
        end
        state_out = crc;
    end

endmodule

`default_nettype wire

//--- eth_fcs_check.sv
// FCS checker FSM with one-beat hold, tail removal and CRC verdict
`timescale 1ns/1ps
`default_nettype none

`include "eth_fcs_macros.svh"

module eth_fcs_check
    import eth_fcs_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    input  wire axis_beat_t in_beat,
    input  wire logic       in_valid,
    output logic            in_ready,

    output axis_beat_t      int_beat,
    output logic            int_valid,
    input  wire logic       ready_early,

    input  wire logic       check_en,
    output logic            busy,
    output logic            error_bad_fcs,
    output logic            frame_done,
    output logic            frame_bad
);

    fcs_state_e state_q;
    fcs_state_e state_next;

    // registered copy of the buffer's early ready
    logic       ready_int_q;
    logic       in_ready_q;
    logic       busy_q;
    logic       error_q;

    // running CRC over whole beats and a copy advanced by the low four bytes
    crc_t       crc_q;
    crc_t       crc4_q;

    // previous beat held back so the FCS can be cut off
    axis_beat_t hold_beat_q;
    logic       hold_valid_q;

    logic       accept;
    logic       last_cycle;
    logic       shift_in;
    logic       shift_reset;
    logic       crc_ok;
    logic       bad;

    // partial CRC inputs shared by the 1..4 byte steps
    logic [31:0] part_data;
    crc_t        part_state;
    logic [3:0]  tail_keep;

    crc_t crc1;
    crc_t crc2;
    crc_t crc3;
    crc_t crc4;
    crc_t crc8;

    assign accept        = in_ready_q & in_valid;
    assign last_cycle    = (state_q == FCS_LAST);
    assign in_ready      = in_ready_q;
    assign busy          = busy_q;
    assign error_bad_fcs = error_q;

    // in the last state the tail bytes sit in the upper half of the held beat
    assign part_data  = last_cycle ? hold_beat_q.data[63:32] : in_beat.data[31:0];
    assign part_state = last_cycle ? crc4_q : crc_q;
    assign tail_keep  = last_cycle ? hold_beat_q.keep[7:4] : in_beat.keep[3:0];

    eth_crc32_step #(.BYTES(1)) u_crc1 (
        .data_in(part_data[7:0]), .state_in(part_state), .state_out(crc1)
    );
    eth_crc32_step #(.BYTES(2)) u_crc2 (
        .data_in(part_data[15:0]), .state_in(part_state), .state_out(crc2)
    );
    eth_crc32_step #(.BYTES(3)) u_crc3 (
        .data_in(part_data[23:0]), .state_in(part_state), .state_out(crc3)
    );
    eth_crc32_step #(.BYTES(4)) u_crc4 (
        .data_in(part_data), .state_in(part_state), .state_out(crc4)
    );
    eth_crc32_step #(.BYTES(8)) u_crc8 (
        .data_in(in_beat.data), .state_in(crc_q), .state_out(crc8)
    );

    // pick the partial CRC that ends exactly at the last frame byte
    always_comb begin
        case (tail_keep)
            4'b0001: crc_ok = (crc1 == `ETH_CRC_RESIDUE);
            4'b0011: crc_ok = (crc2 == `ETH_CRC_RESIDUE);
            4'b0111: crc_ok = (crc3 == `ETH_CRC_RESIDUE);
            4'b1111: crc_ok = (crc4 == `ETH_CRC_RESIDUE);
            default: crc_ok = 1'b0;
        endcase
    end

    assign bad = ~crc_ok & check_en;

    always_comb begin
        state_next  = state_q;
        shift_in    = 1'b0;
        shift_reset = 1'b0;
        frame_done  = 1'b0;
        frame_bad   = 1'b0;
        int_beat    = hold_beat_q;
        int_valid   = 1'b0;

        case (state_q)
            FCS_IDLE, FCS_PAYLOAD: begin
                // held beat goes out as the next one comes in
                int_valid     = hold_valid_q & accept;
                int_beat.last = 1'b0;
                int_beat.user = 1'b0;
                if (accept) begin
                    shift_in   = 1'b1;
                    state_next = FCS_PAYLOAD;
                    if (in_beat.last) begin
                        if (in_beat.keep[7:4] == 4'h0) begin
                            // whole final beat is FCS so the held beat gets trimmed
                            int_beat.keep = {in_beat.keep[3:0], 4'hF};
                            int_beat.last = 1'b1;
                            int_beat.user = in_beat.user | bad;
                            shift_reset   = 1'b1;
                            frame_done    = 1'b1;
                            frame_bad     = bad;
                            state_next    = FCS_IDLE;
                        end else begin
                            state_next = FCS_LAST;
                        end
                    end
                end
            end
            FCS_LAST: begin
                // shortened final beat while the input is stalled
                int_valid     = hold_valid_q;
                int_beat.keep = {4'h0, hold_beat_q.keep[7:4]};
                int_beat.last = 1'b1;
                int_beat.user = hold_beat_q.user | bad;
                if (ready_int_q) begin
                    shift_reset = 1'b1;
                    frame_done  = 1'b1;
                    frame_bad   = bad;
                    state_next  = FCS_IDLE;
                end
            end
            default: begin
                state_next = FCS_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q      <= FCS_IDLE;
            ready_int_q  <= 1'b0;
            in_ready_q   <= 1'b0;
            busy_q       <= 1'b0;
            error_q      <= 1'b0;
            hold_valid_q <= 1'b0;
            crc_q        <= `ETH_CRC_SEED;
            crc4_q       <= `ETH_CRC_SEED;
        end else begin
            state_q     <= state_next;
            ready_int_q <= ready_early;
            in_ready_q  <= ready_early & (state_next != FCS_LAST);
            busy_q      <= (state_next != FCS_IDLE);
            error_q     <= frame_bad;

            // restart CRC at frame end
            if (shift_reset) begin
                crc_q  <= `ETH_CRC_SEED;
                crc4_q <= `ETH_CRC_SEED;
            end else if (shift_in) begin
                crc_q  <= crc8;
                crc4_q <= crc4;
            end

            if (shift_reset) begin
                hold_valid_q <= 1'b0;
            end else if (shift_in) begin
                hold_valid_q <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (shift_in) begin
            hold_beat_q <= in_beat;
        end
    end

endmodule

`default_nettype wire

//--- eth_fcs_macros.svh
// CRC-32 polynomial, seed and residue constants, and the frame counter width
`ifndef ETH_FCS_MACROS_SVH
`define ETH_FCS_MACROS_SVH

// reflected form of 0x04C11DB7 for a shift-right LFSR
`define ETH_CRC_POLY 32'hEDB88320

// running CRC starts from all ones
`define ETH_CRC_SEED 32'hFFFFFFFF

// register value left once a good frame and its FCS have been shifted in
// which is the bit inverse of the magic 0x2144DF1C
`define ETH_CRC_RESIDUE 32'hDEBB20E3

// width of the good and bad frame counters
`define ETH_STAT_W 16

`endif

//--- eth_fcs_pkg.sv
// stream beat struct, datapath width typedefs and the FCS checker state enum
`default_nettype none

`include "eth_fcs_macros.svh"

package eth_fcs_pkg;

    // eight byte lanes with lane 0 in bits 7:0
    typedef logic [63:0] axis_data_t;

    // one enable bit per byte lane
    typedef logic [7:0] axis_keep_t;

    // running CRC register
    typedef logic [31:0] crc_t;

    // frame counter
    typedef logic [`ETH_STAT_W-1:0] stat_cnt_t;

    // one beat of the byte stream
    typedef struct packed {
        axis_data_t data;
        axis_keep_t keep;
        logic       last;
        // error flag set on the last beat of a bad frame
        logic       user;
    } axis_beat_t;

    // checker FSM
    typedef enum logic [1:0] {
        FCS_IDLE,
        FCS_PAYLOAD,
        FCS_LAST
    } fcs_state_e;

endpackage

`default_nettype wire

//--- eth_fcs_rx_assert.sv
// concurrent checks on output stalls, reset behavior and the bad FCS pulse, with their bind
`timescale 1ns/1ps
`default_nettype none

module eth_fcs_rx_assert
    import eth_fcs_pkg::*;
(
    input wire logic       clk,
    input wire logic       rst,
    input wire axis_beat_t out_beat,
    input wire logic       out_valid,
    input wire logic       out_ready,
    input wire axis_beat_t int_beat,
    input wire logic       int_valid,
    input wire logic       error_bad_fcs
);

    int fail_count = 0;

    // a stalled beat stays put until it transfers
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat))
    else begin
        fail_count++;
        $error("stalled output beat changed or was withdrawn");
    end

    reset_quiet: assert property (@(posedge clk) rst |=> !out_valid)
    else begin
        fail_count++;
        $error("output valid while in reset");
    end

    // pulse comes one cycle after the flagged last beat leaves the checker
    error_after_bad: assert property (@(posedge clk) disable iff (rst)
        error_bad_fcs |-> $past(int_valid && int_beat.last && int_beat.user))
    else begin
        fail_count++;
        $error("error pulse without a preceding flagged last beat");
    end

endmodule

bind eth_fcs_rx_top eth_fcs_rx_assert u_assert (
    .clk(clk), .rst(rst),
    .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready),
    .int_beat(int_beat), .int_valid(int_valid), .error_bad_fcs(error_bad_fcs)
);

`default_nettype wire

//--- eth_fcs_rx_top.sv
// receive FCS checker top with output skid buffer and status register block
`timescale 1ns/1ps
`default_nettype none

module eth_fcs_rx_top
    import eth_fcs_pkg::*;
(
    input  wire logic       clk,
    input  wire logic       rst,

    input  wire axis_beat_t in_beat,
    input  wire logic       in_valid,
    output logic            in_ready,

    output axis_beat_t      out_beat,
    output logic            out_valid,
    input  wire logic       out_ready,

    input  wire logic       cfg_wr,
    input  wire logic       cfg_check_en,
    input  wire logic       stats_clear,

    output logic            check_en,
    output stat_cnt_t       good_count,
    output stat_cnt_t       bad_count,
    output logic            busy,
    output logic            error_bad_fcs
);

    axis_beat_t int_beat;
    logic       int_valid;
    logic       ready_early;
    logic       frame_done;
    logic       frame_bad;

    eth_fcs_check u_check (
        .clk(clk), .rst(rst),
        .in_beat(in_beat), .in_valid(in_valid), .in_ready(in_ready),
        .int_beat(int_beat), .int_valid(int_valid), .ready_early(ready_early),
        .check_en(check_en), .busy(busy), .error_bad_fcs(error_bad_fcs),
        .frame_done(frame_done), .frame_bad(frame_bad)
    );

    axis_skid_buffer u_skid (
        .clk(clk), .rst(rst),
        .int_beat(int_beat), .int_valid(int_valid), .ready_early(ready_early),
        .out_beat(out_beat), .out_valid(out_valid), .out_ready(out_ready)
    );

    eth_fcs_stats u_stats (
        .clk(clk), .rst(rst),
        .cfg_wr(cfg_wr), .cfg_check_en(cfg_check_en), .stats_clear(stats_clear),
        .frame_done(frame_done), .frame_bad(frame_bad),
        .check_en(check_en), .good_count(good_count), .bad_count(bad_count)
    );

endmodule

`default_nettype wire

//--- eth_fcs_stats.sv
// check-enable register and saturating good and bad frame counters
`timescale 1ns/1ps
`default_nettype none

module eth_fcs_stats
    import eth_fcs_pkg::*;
(
    input  wire logic clk,
    input  wire logic rst,

    input  wire logic cfg_wr,
    input  wire logic cfg_check_en,
    input  wire logic stats_clear,

    input  wire logic frame_done,
    input  wire logic frame_bad,

    output logic      check_en,
    output stat_cnt_t good_count,
    output stat_cnt_t bad_count
);

    logic      check_en_q;
    stat_cnt_t good_q;
    stat_cnt_t bad_q;

    assign check_en   = check_en_q;
    assign good_count = good_q;
    assign bad_count  = bad_q;

    // checking on by default
    always_ff @(posedge clk) begin
        if (rst) begin
            check_en_q <= 1'b1;
        end else if (cfg_wr) begin
            check_en_q <= cfg_check_en;
        end
    end

    // clear wins over a frame ending on the same cycle
    always_ff @(posedge clk) begin
        if (rst || stats_clear) begin
            good_q <= '0;
            bad_q  <= '0;
        end else if (frame_done) begin
            if (frame_bad) begin
                if (bad_q != '1) begin
                    bad_q <= bad_q + 1'b1;
                end
            end else if (good_q != '1) begin
                good_q <= good_q + 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- run.sh
#!/bin/sh
# build and run the FCS checker testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_eth_fcs_rx \
    -f verilog.f -o sim_tb

# assertion errors must not stop the run before the testbench reports
./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log

if grep -q "^Verification passed$" sim.log; then
    exit 0
else
    exit 1
fi

//--- tb_eth_fcs_rx.sv
// FCS checker testbench with reference CRC, frame driver, output monitor and typed compares
`timescale 1ns/1ps
`default_nettype none

module tb_eth_fcs_rx
    import eth_fcs_pkg::*;
();

    // about 60 frames of at most three beats; random stalls stretch a frame to a few tens
    // of cycles, so the whole run stays well under 2000 cycles
    localparam int   MAX_CYCLES = 20000;
    localparam crc_t POLY       = 32'hEDB88320;

    typedef byte unsigned byte_q_t[$];
    typedef axis_beat_t   beat_q_t[$];

    logic       clk = 1'b0;
    logic       rst;
    axis_beat_t in_beat;
    logic       in_valid;
    logic       in_ready;
    axis_beat_t out_beat;
    logic       out_valid;
    logic       out_ready = 1'b0;
    logic       cfg_wr;
    logic       cfg_check_en;
    logic       stats_clear;
    logic       check_en;
    stat_cnt_t  good_count;
    stat_cnt_t  bad_count;
    logic       busy;
    logic       error_bad_fcs;

    beat_q_t   out_q;
    beat_q_t   exp_q;
    int        errors = 0;
    int        cycles = 0;
    int        err_pulses = 0;
    int        exp_pulses = 0;
    stat_cnt_t exp_good = '0;
    stat_cnt_t exp_bad = '0;
    bit        stall_out = 1'b0;
    bit        gap_in = 1'b0;
    bit        check_on = 1'b1;
    string     test_name = "reset";

    eth_fcs_rx_top DUT (.*);

    always #4 clk = ~clk;

    // sink side optionally stalled at random
    always @(posedge clk) begin
        #1;
        out_ready = stall_out ? ($urandom % 2 == 1) : 1'b1;
    end

    // output monitor and cycle limit
    always @(negedge clk) begin
        cycles++;
        if (!rst && out_valid && out_ready)
            out_q.push_back(out_beat);
        if (!rst && error_bad_fcs)
            err_pulses++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout after %0d cycles, the DUT stopped delivering output", cycles);
            $display("Verification failed");
            $finish;
        end
    end

    // bytewise reflected CRC-32; the FCS is its complement, low byte first
    function automatic crc_t ref_crc(input byte_q_t bytes);
        crc_t c;
        c = 32'hFFFFFFFF;
        foreach (bytes[i]) begin
            c = c ^ {24'h0, bytes[i]};
            for (int b = 0; b < 8; b++)
                c = c[0] ? ((c >> 1) ^ POLY) : (c >> 1);
        end
        return ~c;
    endfunction

    // cut a byte string into beats with keep contiguous from lane 0
    function automatic beat_q_t to_beats(input byte_q_t bytes, input logic user);
        beat_q_t    q;
        axis_beat_t b;
        b = '0;
        foreach (bytes[i]) begin
            b.data[(i % 8) * 8 +: 8] = bytes[i];
            b.keep[i % 8] = 1'b1;
            if (i % 8 == 7 || i == bytes.size() - 1) begin
                b.last = (i == bytes.size() - 1);
                b.user = b.last & user;
                q.push_back(b);
                b = '0;
            end
        end
        return q;
    endfunction

    task automatic drive_beat(input axis_beat_t b);
        in_beat  = b;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready)
            @(negedge clk);
        @(posedge clk);
        #1;
        in_valid = 1'b0;
        if (gap_in) begin
            repeat ($urandom % 3) begin
                @(posedge clk);
                #1;
            end
        end
    endtask

    task automatic compare_beat(input axis_beat_t exp_b, input axis_beat_t act_b);
        axis_data_t mask;
        for (int i = 0; i < 8; i++)
            mask[i * 8 +: 8] = {8{exp_b.keep[i]}};
        if ((act_b.data & mask) !== (exp_b.data & mask) || act_b.keep !== exp_b.keep ||
            act_b.last !== exp_b.last || act_b.user !== exp_b.user) begin
            errors++;
            $display("** Error %s: beat expected %h actual %h", test_name, exp_b, act_b);
        end
    endtask

    task automatic compare_count(input string what, input stat_cnt_t exp_c,
                                 input stat_cnt_t act_c);
        if (act_c !== exp_c) begin
            errors++;
            $display("** Error %s: %s expected %0d actual %0d", test_name, what, exp_c, act_c);
        end
    endtask

    task automatic compare_flag(input string what, input logic exp_f, input logic act_f);
        if (act_f !== exp_f) begin
            errors++;
            $display("** Error %s: %s expected %b actual %b", test_name, what, exp_f, act_f);
        end
    endtask

    // one frame with its FCS; queues the expected output and verdict
    task automatic run_frame(input int len, input bit corrupt, input logic user_in);
        byte_q_t bytes;
        byte_q_t payload;
        beat_q_t beats;
        crc_t    fcs;
        logic    bad;
        for (int i = 0; i < len - 4; i++)
            bytes.push_back(8'($urandom));
        fcs = ref_crc(bytes);
        for (int i = 0; i < 4; i++)
            bytes.push_back(fcs[i * 8 +: 8]);
        if (corrupt)
            bytes[$urandom % len] ^= 8'($urandom_range(255, 1));
        bad     = corrupt & check_on;
        payload = bytes;
        repeat (4) void'(payload.pop_back());
        beats = to_beats(payload, user_in | bad);
        foreach (beats[i])
            exp_q.push_back(beats[i]);
        if (bad) begin
            exp_bad++;
            exp_pulses++;
        end else begin
            exp_good++;
        end
        beats = to_beats(bytes, user_in);
        drive_beat(beats[0]);
        // the frame is under way once its first beat is taken
        compare_flag("busy", 1'b1, busy);
        for (int i = 1; i < beats.size(); i++)
            drive_beat(beats[i]);
    endtask

    // drain, then compare beats, counters and error pulses
    task automatic check_frames();
        while (out_q.size() < exp_q.size())
            @(negedge clk);
        repeat (3) @(negedge clk);
        while (exp_q.size() > 0)
            compare_beat(exp_q.pop_front(), out_q.pop_front());
        if (out_q.size() != 0) begin
            errors++;
            $display("%s: the DUT sent %0d output beats that no frame accounts for",
                     test_name, out_q.size());
            out_q = {};
        end
        compare_count("good_count", exp_good, good_count);
        compare_count("bad_count", exp_bad, bad_count);
        compare_flag("busy", 1'b0, busy);
        if (err_pulses != exp_pulses) begin
            errors++;
            $display("** Error %s: error pulses expected %0d actual %0d",
                     test_name, exp_pulses, err_pulses);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic write_check_en(input logic en);
        cfg_wr       = 1'b1;
        cfg_check_en = en;
        @(posedge clk);
        #1;
        cfg_wr   = 1'b0;
        check_on = en;
        compare_flag("check_en", en, check_en);
    endtask

    task automatic clear_stats();
        stats_clear = 1'b1;
        @(posedge clk);
        #1;
        stats_clear = 1'b0;
        exp_good    = '0;
        exp_bad     = '0;
    endtask

    // idle state right after reset
    task automatic reset_defaults();
        test_name = "reset";
        compare_flag("check_en", 1'b1, check_en);
        compare_flag("busy", 1'b0, busy);
        compare_flag("in_ready", 1'b0, in_ready);
        compare_flag("out_valid", 1'b0, out_valid);
        compare_count("good_count", '0, good_count);
        compare_count("bad_count", '0, bad_count);
    endtask

    task automatic good_lengths();
        test_name = "good_lengths";
        for (int len = 16; len <= 23; len++) begin
            run_frame(len, 1'b0, 1'b0);
            check_frames();
        end
    endtask

    // final input beats of 1, 4, 8, 5 and 7 bytes
    task automatic bad_frames();
        int lens[5] = '{17, 20, 16, 21, 23};
        test_name = "bad_frames";
        foreach (lens[i]) begin
            run_frame(lens[i], 1'b1, 1'b0);
            check_frames();
        end
    endtask

    task automatic user_passthrough();
        test_name = "user_passthrough";
        run_frame(19, 1'b0, 1'b1);
        run_frame(22, 1'b0, 1'b1);
        check_frames();
    endtask

    task automatic random_stalls();
        test_name = "random_stalls";
        stall_out = 1'b1;
        gap_in    = 1'b1;
        repeat (40) run_frame(16 + $urandom % 8, $urandom % 3 == 0, 1'b0);
        check_frames();
        stall_out = 1'b0;
        gap_in    = 1'b0;
    endtask

    task automatic check_disable();
        test_name = "check_disable";
        write_check_en(1'b0);
        run_frame(18, 1'b1, 1'b0);
        run_frame(22, 1'b1, 1'b0);
        check_frames();
        write_check_en(1'b1);
        run_frame(20, 1'b1, 1'b0);
        check_frames();
    endtask

    task automatic stats_reset();
        test_name = "stats_reset";
        clear_stats();
        check_frames();
        run_frame(16, 1'b0, 1'b0);
        run_frame(21, 1'b1, 1'b0);
        run_frame(19, 1'b0, 1'b0);
        check_frames();
    endtask

    initial begin
        int total;
        void'($urandom(32'ha709e87c));
        rst          = 1'b1;
        in_beat      = '0;
        in_valid     = 1'b0;
        cfg_wr       = 1'b0;
        cfg_check_en = 1'b1;
        stats_clear  = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        reset_defaults();
        good_lengths();
        bad_frames();
        user_passthrough();
        random_stalls();
        check_disable();
        stats_reset();
        total = errors + DUT.u_assert.fail_count;
        $display("errors: %0d compare, %0d assertion", errors, DUT.u_assert.fail_count);
        if (total == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
eth_fcs_pkg.sv
eth_crc32_step.sv
eth_fcs_check.sv
axis_skid_buffer.sv
eth_fcs_stats.sv
eth_fcs_rx_top.sv
eth_fcs_rx_assert.sv
tb_eth_fcs_rx.sv
